// ==== Bender.yml ====
package:
  name: cpu_frontend

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cpu_pkg.sv
      - verilog/decode.sv
      - verilog/cycle_timer.sv
      - verilog/pc_unit.sv
      - verilog/instr_sequencer.sv
      - verilog/cpu_frontend.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/cpu_frontend_assertions.sv
      - verif/cpu_frontend_tb.sv

// ==== verif/cpu_frontend_assertions.sv ====
`include "cpu_macros.svh"

module cpu_frontend_assertions (
    input logic             clk,
    input logic             reset,
    input logic             clk_en,
    input logic             instr_start,
    input logic             irq_ack,
    input logic             halted,
    input logic [`PC_W-1:0] pc
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;   // Checked by the testbench at the end

    a_start_ack: assert property (@(posedge clk) disable iff (reset)
        !(instr_start && irq_ack))
        else begin
            fail_count++;
            $error("instr_start and irq_ack high together");
        end

    // pc moves only on the final tick, which is an enabled tick
    a_pc_update: assert property (@(posedge clk) disable iff (reset)
        (pc != $past(pc)) |-> $past(clk_en))
        else begin
            fail_count++;
            $error("pc changed after a tick without clk_en");
        end

    a_start_run: assert property (@(posedge clk) disable iff (reset)
        instr_start |-> !halted)
        else begin
            fail_count++;
            $error("instr_start while halted");
        end

endmodule

bind cpu_frontend cpu_frontend_assertions asrt0 (
    .clk         (clk),
    .reset       (reset),
    .clk_en      (clk_en),
    .instr_start (instr_start),
    .irq_ack     (irq_ack),
    .halted      (halted),
    .pc          (pc)
);

// ==== verif/cpu_frontend_tb.sv ====
`include "cpu_macros.svh"

module cpu_frontend_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_TESTS = 64;
    localparam int HALT_WAIT = 3;   // Enabled ticks parked before the interrupt

    logic                 clk;
    logic                 reset;
    logic                 clk_en;
    logic [`OPCODE_W-1:0] opcode;
    logic                 irq_request;
    logic                 jump_load;
    logic [`PC_W-1:0]     jump_target;
    logic [`PC_W-1:0]     pc;
    logic                 instr_start;
    logic [`UADDR_W-1:0]  microcode_start_addr;
    cpu_pkg::instr_length cycle_length;
    logic [`IMMED_W-1:0]  immed;
    logic                 irq_ack;
    logic                 halted;

    logic [31:0] tests [0:MAX_TESTS-1];   // {opcode, addr, length, flags, control}
    int          n_tests;
    bit          loaded;
    logic [31:0] seed;

    cpu_frontend dut0 (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int length_ticks(input cpu_pkg::instr_length len);
        case (len)
            cpu_pkg::CYCLE5:  return 5;
            cpu_pkg::CYCLE7:  return 7;
            cpu_pkg::CYCLE12: return 12;
            default:          return 0;
        endcase
    endfunction

    function automatic cpu_pkg::instr_length vec_length(input int i);
        return cpu_pkg::instr_length'(tests[i][9:8]);
    endfunction

    task automatic stop_run();
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_uaddr(input string name, input logic [`UADDR_W-1:0] exp, act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_length(input string name, input cpu_pkg::instr_length exp, act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %s, got %s (%0d)", $time, name, exp.name(),
                     act.name(), act);
            stop_run();
        end
    endtask

    task automatic check_pc(input string name, input logic [`PC_W-1:0] exp, act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_immed(input string name, input logic [`IMMED_W-1:0] exp, act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_ticks(input int exp, input int act);
        if (act != exp) begin
            $display("Fail at %0t: enabled ticks expected %0d, got %0d", $time, exp, act);
            stop_run();
        end
    endtask

    // Budget is the worst case of 12 ticks at one tick in four clocks
    initial begin
        wait (loaded);
        #(n_tests * 12 * 4 * 100 + 8 * 100);
        $display("Timeout: the instruction stream did not complete in time");
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int               ticks;        // Enabled ticks since the last fetch tick
        int               acks;
        int               halt_ticks;
        int               fetched;
        int               cur;
        bit               executing;
        bit               model_halted;
        bit               req_held;     // irq_request level while cur executes
        logic [`PC_W-1:0] model_pc;

        $timeformat(-9, 1, " ns", 0);
        clk = 1'b0;
        reset = 1'b1;
        clk_en = 1'b0;
        opcode = '0;
        irq_request = 1'b0;
        jump_load = 1'b0;
        jump_target = '0;
        seed = 32'h4664;
        ticks = 0;
        acks = 0;
        halt_ticks = 0;
        fetched = 0;
        executing = 1'b0;
        model_halted = 1'b0;
        req_held = 1'b0;
        model_pc = '0;

        $readmemh("verif/cpu_frontend_tests.txt", tests);
        n_tests = 0;
        while (n_tests < MAX_TESTS && !$isunknown(tests[n_tests]))
            n_tests++;
        if (n_tests == 0)
            report_error("the test file holds no vectors");
        loaded = 1'b1;

        repeat (8) @(negedge clk);
        check_pc("pc", '0, pc);
        check_bit("instr_start", 1'b0, instr_start);
        check_bit("irq_ack", 1'b0, irq_ack);
        check_bit("halted", 1'b0, halted);
        check_uaddr("microcode_start_addr", '0, microcode_start_addr);
        check_length("cycle_length", cpu_pkg::CYCLE5, cycle_length);
        check_immed("immed", '0, immed);
        reset = 1'b0;
        opcode = tests[0][31:20];   // ROM answers with the next vector
        seed = lcg_next(seed);
        clk_en = seed[31:30] != 2'b00;

        while (fetched <= n_tests) begin
            @(negedge clk);
            if (instr_start && irq_ack)
                report_error("instr_start and irq_ack pulsed in the same clock");
            if (irq_ack && !(irq_request && clk_en))
                report_error("irq_ack pulsed without a request on an enabled tick");
            if (model_halted && clk_en && irq_request)
                check_bit("irq_ack", 1'b1, irq_ack);
            if (irq_ack) begin
                acks++;
                model_halted = 1'b0;
                irq_request = 1'b0;
            end
            if (instr_start) begin
                if (executing)
                    report_error("a fetch came before the previous instruction ended");
                if (fetched > 0) begin
                    cur = fetched - 1;
                    if (tests[cur][6]) begin
                        check_bit("irq_ack before fetch", 1'b1, acks != 0);
                    end else begin
                        check_ticks(length_ticks(vec_length(cur)) + acks, ticks);
                        check_bit("irq_ack before fetch", req_held && !tests[cur][5], acks != 0);
                    end
                end
                if (fetched < n_tests) begin
                    check_uaddr("microcode_start_addr", tests[fetched][18:12],
                                microcode_start_addr);
                    check_length("cycle_length", vec_length(fetched), cycle_length);
                    check_immed("immed", tests[fetched][27:20], immed);
                    seed = lcg_next(seed);
                    jump_target = seed[27:16];
                    jump_load = tests[fetched][0];
                    if (tests[fetched][1] && !tests[fetched][6])
                        irq_request = 1'b1;   // Taken at the coming boundary
                end
                req_held = irq_request;
                fetched++;
                opcode = fetched < n_tests ? tests[fetched][31:20] : 12'hFFB;
                ticks = 1;
                acks = 0;
                executing = 1'b1;
            end else if (clk_en) begin
                ticks++;
                if (model_halted) begin
                    halt_ticks++;
                    if (halt_ticks == HALT_WAIT && tests[fetched - 1][1])
                        irq_request = 1'b1;   // Wake the parked core
                end
                if (executing && ticks == length_ticks(vec_length(fetched - 1))) begin
                    executing = 1'b0;   // Final tick of the instruction
                    if (tests[fetched - 1][0])
                        model_pc = jump_target;
                    else if (!tests[fetched - 1][4])
                        model_pc = model_pc + 1'b1;
                    if (tests[fetched - 1][6]) begin
                        model_halted = 1'b1;
                        halt_ticks = 0;
                    end
                end
            end
            check_pc("pc", model_pc, pc);
            check_bit("halted", model_halted, halted);
            seed = lcg_next(seed);
            clk_en = seed[31:30] != 2'b00;   // About three ticks in four
        end

        if (dut0.asrt0.fail_count == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== verif/cpu_frontend_tests.txt ====
// opcode _ microcode address _ length code (0: 5, 1: 7, 2: 12 ticks)
// _ flags {halt, interrupt off, skip} _ control {irq_request, jump_load}
0a5_00_0_0_0
123_01_2_1_0
4f0_04_1_1_0
a37_0d_1_0_0
c45_1c_1_0_0
b12_1a_0_0_1
e9c_00_0_0_0
e45_24_0_2_2
ec3_34_0_0_0
fde_57_2_0_0
ff8_5e_0_4_2
fdf_58_1_1_0
fe8_5b_0_1_1
f23_00_0_0_0
f2b_39_1_0_0
7c4_07_0_0_2
ff9_5f_0_4_2
fff_61_1_0_0
fdc_00_0_0_0
540_05_1_1_2
d9f_21_1_0_0
fc7_49_0_0_0
ffb_60_0_0_0

// ==== verilog.f ====
+incdir+verilog
verilog/cpu_pkg.sv
verilog/decode.sv
verilog/cycle_timer.sv
verilog/pc_unit.sv
verilog/instr_sequencer.sv
verilog/cpu_frontend.sv
verif/cpu_frontend_assertions.sv
verif/cpu_frontend_tb.sv

// ==== verilog/cpu_frontend.sv ====
`include "cpu_macros.svh"

module cpu_frontend (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clk_en,
    input  logic [`OPCODE_W-1:0]  opcode,
    input  logic                  irq_request,
    input  logic                  jump_load,
    input  logic [`PC_W-1:0]      jump_target,
    output logic [`PC_W-1:0]      pc,
    output logic                  instr_start,
    output logic [`UADDR_W-1:0]   microcode_start_addr,
    output cpu_pkg::instr_length  cycle_length,
    output logic [`IMMED_W-1:0]   immed,
    output logic                  irq_ack,
    output logic                  halted
);

    logic decode_en;
    logic load_en;
    logic advance_en;
    logic skip_pc_increment;
    logic disable_interrupt;
    logic halt;
    logic last_tick;

    decode decode0 (
        .clk                  (clk),
        .reset                (reset),
        .decode_en            (decode_en),
        .opcode               (opcode),
        .skip_pc_increment    (skip_pc_increment),
        .microcode_start_addr (microcode_start_addr),
        .cycle_length         (cycle_length),
        .disable_interrupt    (disable_interrupt),
        .halt                 (halt),
        .immed                (immed)
    );

    cycle_timer cycle_timer0 (
        .clk          (clk),
        .reset        (reset),
        .clk_en       (clk_en),
        .load_en      (load_en),
        .cycle_length (cycle_length),
        .last_tick    (last_tick)
    );

    pc_unit pc_unit0 (
        .clk               (clk),
        .reset             (reset),
        .advance_en        (advance_en),
        .skip_pc_increment (skip_pc_increment),
        .jump_load         (jump_load),
        .jump_target       (jump_target),
        .pc                (pc)
    );

    instr_sequencer instr_sequencer0 (
        .clk               (clk),
        .reset             (reset),
        .clk_en            (clk_en),
        .irq_request       (irq_request),
        .last_tick         (last_tick),
        .disable_interrupt (disable_interrupt),
        .halt              (halt),
        .decode_en         (decode_en),
        .load_en           (load_en),
        .advance_en        (advance_en),
        .instr_start       (instr_start),
        .irq_ack           (irq_ack),
        .halted            (halted)
    );

endmodule

// ==== verilog/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Opcode word from the program ROM
`define OPCODE_W 12

// Program counter, wraps modulo 4096
`define PC_W 12

// Microcode start address
`define UADDR_W 7

// Immediate field, low byte of the opcode
`define IMMED_W 8

`endif

// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

    // Instruction length in enabled ticks
    typedef enum logic [1:0] {
        CYCLE5,   // 5 ticks
        CYCLE7,   // 7 ticks
        CYCLE12   // 12 ticks
    } instr_length;

    // Instruction sequencer states
    typedef enum logic [1:0] {
        FETCH,    // Waiting for a fetch tick
        EXECUTE,  // Counting out the instruction
        HALTED    // Parked until an interrupt
    } seq_state;

endpackage

// ==== verilog/cycle_timer.sv ====
module cycle_timer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 clk_en,
    input  logic                 load_en,
    input  cpu_pkg::instr_length cycle_length,
    output logic                 last_tick
);

    logic [3:0] count;     // Enabled ticks left before the final one
    logic       pending;   // Length not yet registered by decode
    logic [3:0] span;      // Length minus 2

    always_comb begin
        case (cycle_length)
            cpu_pkg::CYCLE5:  span = 4'd3;
            cpu_pkg::CYCLE7:  span = 4'd5;
            cpu_pkg::CYCLE12: span = 4'd10;
            default:          span = 4'd3;
        endcase
    end

    // The fetch tick only arms the timer. The count is taken one clock
    // later, once decode holds the new length; a tick in that clock counts.
    always_ff @(posedge clk) begin
        if (reset) begin
            count   <= 4'd0;
            pending <= 1'b0;
        end else if (load_en) begin
            pending <= 1'b1;
        end else if (pending) begin
            pending <= 1'b0;
            count   <= clk_en ? span - 4'd1 : span;
        end else if (clk_en && count != 4'd0) begin
            count <= count - 4'd1;
        end
    end

    assign last_tick = !pending && count == 4'd0;

endmodule

// ==== verilog/decode.sv ====
`include "cpu_macros.svh"

module decode (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    decode_en,
    input  logic [`OPCODE_W-1:0]    opcode,
    output logic                    skip_pc_increment,
    output logic [`UADDR_W-1:0]     microcode_start_addr,
    output cpu_pkg::instr_length    cycle_length,
    output logic                    disable_interrupt,
    output logic                    halt,
    output logic [`IMMED_W-1:0]     immed
);

    logic [`UADDR_W+1:0] entry;   // Address in the upper bits, length in [1:0]
    logic                skip_d;
    logic                dis_d;
    logic                halt_d;

    always_comb begin
        entry  = {7'd0, cpu_pkg::CYCLE5};   // Invalid patterns land here
        skip_d = 1'b0;
        dis_d  = 1'b0;
        halt_d = 1'b0;
        casez (opcode)
            12'h0??: entry = {7'd0, cpu_pkg::CYCLE5};    // JP s
            12'h1??: begin                               // RETD e
                entry  = {7'd1, cpu_pkg::CYCLE12};
                skip_d = 1'b1;
            end
            12'h2??: entry = {7'd2, cpu_pkg::CYCLE5};    // JP C, s
            12'h3??: entry = {7'd3, cpu_pkg::CYCLE5};    // JP NC, s
            12'h4??: begin                               // CALL s
                entry  = {7'd4, cpu_pkg::CYCLE7};
                skip_d = 1'b1;
            end
            12'h5??: begin                               // CALZ s
                entry  = {7'd5, cpu_pkg::CYCLE7};
                skip_d = 1'b1;
            end
            12'h6??: entry = {7'd6, cpu_pkg::CYCLE5};    // JP Z, s
            12'h7??: entry = {7'd7, cpu_pkg::CYCLE5};    // JP NZ, s
            12'h8??: entry = {7'd8, cpu_pkg::CYCLE5};    // LD Y, e
            12'h9??: entry = {7'd9, cpu_pkg::CYCLE5};    // LBPX MX, e
            12'hA0?: entry = {7'd10, cpu_pkg::CYCLE7};   // ADC XH, i
            12'hA1?: entry = {7'd11, cpu_pkg::CYCLE7};   // ADC XL, i
            12'hA2?: entry = {7'd12, cpu_pkg::CYCLE7};   // ADC YH, i
            12'hA3?: entry = {7'd13, cpu_pkg::CYCLE7};   // ADC YL, i
            12'hA4?: entry = {7'd14, cpu_pkg::CYCLE7};   // CP XH, i
            12'hA5?: entry = {7'd15, cpu_pkg::CYCLE7};   // CP XL, i
            12'hA6?: entry = {7'd16, cpu_pkg::CYCLE7};   // CP YH, i
            12'hA7?: entry = {7'd17, cpu_pkg::CYCLE7};   // CP YL, i
            12'hA8?: entry = {7'd18, cpu_pkg::CYCLE7};   // ADD r, q
            12'hA9?: entry = {7'd19, cpu_pkg::CYCLE7};   // ADC r, q
            12'hAA?: entry = {7'd20, cpu_pkg::CYCLE7};   // SUB r, q
            12'hAB?: entry = {7'd21, cpu_pkg::CYCLE7};   // SBC r, q
            12'hAC?: entry = {7'd22, cpu_pkg::CYCLE7};   // AND r, q
            12'hAD?: entry = {7'd23, cpu_pkg::CYCLE7};   // OR r, q
            12'hAE?: entry = {7'd24, cpu_pkg::CYCLE7};   // XOR r, q
            12'hAF?: entry = {7'd25, cpu_pkg::CYCLE7};   // RLC r
            12'hB??: entry = {7'd26, cpu_pkg::CYCLE5};   // LD X, e
            12'b1100_00??_????: entry = {7'd27, cpu_pkg::CYCLE7};   // ADD r, i
            12'b1100_01??_????: entry = {7'd28, cpu_pkg::CYCLE7};   // ADC r, i
            12'b1100_10??_????: entry = {7'd29, cpu_pkg::CYCLE7};   // AND r, i
            12'b1100_11??_????: entry = {7'd30, cpu_pkg::CYCLE7};   // OR r, i
            12'b1101_00??_????: entry = {7'd31, cpu_pkg::CYCLE7};   // XOR r, i
            12'b1101_01??_????: entry = {7'd32, cpu_pkg::CYCLE7};   // SBC r, i
            12'b1101_10??_????: entry = {7'd33, cpu_pkg::CYCLE7};   // FAN r, i
            12'b1101_11??_????: entry = {7'd34, cpu_pkg::CYCLE7};   // CP r, i
            12'b1110_00??_????: entry = {7'd35, cpu_pkg::CYCLE5};   // LD r, i
            12'b1110_010?_????: begin                               // PSET p
                entry = {7'd36, cpu_pkg::CYCLE5};
                dis_d = 1'b1;
            end
            12'hE6?: entry = {7'd37, cpu_pkg::CYCLE5};   // LDPX MX, i
            12'hE7?: entry = {7'd38, cpu_pkg::CYCLE5};   // LDPY MY, i
            12'b1110_1000_00??: entry = {7'd39, cpu_pkg::CYCLE5};   // LD XP, r
            12'b1110_1000_01??: entry = {7'd40, cpu_pkg::CYCLE5};   // LD XH, r
            12'b1110_1000_10??: entry = {7'd41, cpu_pkg::CYCLE5};   // LD XL, r
            12'b1110_1000_11??: entry = {7'd42, cpu_pkg::CYCLE5};   // RRC r
            12'b1110_1001_00??: entry = {7'd43, cpu_pkg::CYCLE5};   // LD YP, r
            12'b1110_1001_01??: entry = {7'd44, cpu_pkg::CYCLE5};   // LD YH, r
            12'b1110_1001_10??: entry = {7'd45, cpu_pkg::CYCLE5};   // LD YL, r
            12'b1110_1010_00??: entry = {7'd46, cpu_pkg::CYCLE5};   // LD r, XP
            12'b1110_1010_01??: entry = {7'd47, cpu_pkg::CYCLE5};   // LD r, XH
            12'b1110_1010_10??: entry = {7'd48, cpu_pkg::CYCLE5};   // LD r, XL
            12'b1110_1011_00??: entry = {7'd49, cpu_pkg::CYCLE5};   // LD r, YP
            12'b1110_1011_01??: entry = {7'd50, cpu_pkg::CYCLE5};   // LD r, YH
            12'b1110_1011_10??: entry = {7'd51, cpu_pkg::CYCLE5};   // LD r, YL
            12'hEC?: entry = {7'd52, cpu_pkg::CYCLE5};   // LD r, q
            12'hEE?: entry = {7'd53, cpu_pkg::CYCLE5};   // LDPX r, q
            12'hEF?: entry = {7'd54, cpu_pkg::CYCLE5};   // LDPY r, q
            12'hF0?: entry = {7'd55, cpu_pkg::CYCLE7};   // CP r, q
            12'hF1?: entry = {7'd56, cpu_pkg::CYCLE7};   // FAN r, q
            12'b1111_0010_10??: entry = {7'd57, cpu_pkg::CYCLE7};   // ACPX MX, r
            12'b1111_0010_11??: entry = {7'd58, cpu_pkg::CYCLE7};   // ACPY MY, r
            12'b1111_0011_10??: entry = {7'd59, cpu_pkg::CYCLE7};   // SCPX MX, r
            12'b1111_0011_11??: entry = {7'd60, cpu_pkg::CYCLE7};   // SCPY MY, r
            12'hF4?: entry = {7'd61, cpu_pkg::CYCLE7};   // SET F, i
            12'hF5?: entry = {7'd62, cpu_pkg::CYCLE7};   // RST F, i
            12'hF6?: entry = {7'd63, cpu_pkg::CYCLE7};   // INC Mn
            12'hF7?: entry = {7'd64, cpu_pkg::CYCLE7};   // DEC Mn
            12'hF8?: entry = {7'd65, cpu_pkg::CYCLE5};   // LD Mn, A
            12'hF9?: entry = {7'd66, cpu_pkg::CYCLE5};   // LD Mn, B
            12'hFA?: entry = {7'd67, cpu_pkg::CYCLE5};   // LD A, Mn
            12'hFB?: entry = {7'd68, cpu_pkg::CYCLE5};   // LD B, Mn
            12'b1111_1100_00??: entry = {7'd69, cpu_pkg::CYCLE5};   // PUSH r
            12'hFC4: entry = {7'd70, cpu_pkg::CYCLE5};   // PUSH XP
            12'hFC5: entry = {7'd71, cpu_pkg::CYCLE5};   // PUSH XH
            12'hFC6: entry = {7'd72, cpu_pkg::CYCLE5};   // PUSH XL
            12'hFC7: entry = {7'd73, cpu_pkg::CYCLE5};   // PUSH YP
            12'hFC8: entry = {7'd74, cpu_pkg::CYCLE5};   // PUSH YH
            12'hFC9: entry = {7'd75, cpu_pkg::CYCLE5};   // PUSH YL
            12'hFCA: entry = {7'd76, cpu_pkg::CYCLE5};   // PUSH F
            12'hFCB: entry = {7'd77, cpu_pkg::CYCLE5};   // DEC SP
            12'b1111_1101_00??: entry = {7'd78, cpu_pkg::CYCLE5};   // POP r
            12'hFD4: entry = {7'd79, cpu_pkg::CYCLE5};   // POP XP
            12'hFD5: entry = {7'd80, cpu_pkg::CYCLE5};   // POP XH
            12'hFD6: entry = {7'd81, cpu_pkg::CYCLE5};   // POP XL
            12'hFD7: entry = {7'd82, cpu_pkg::CYCLE5};   // POP YP
            12'hFD8: entry = {7'd83, cpu_pkg::CYCLE5};   // POP YH
            12'hFD9: entry = {7'd84, cpu_pkg::CYCLE5};   // POP YL
            12'hFDA: entry = {7'd85, cpu_pkg::CYCLE5};   // POP F
            12'hFDB: entry = {7'd86, cpu_pkg::CYCLE5};   // INC SP
            12'hFDE: entry = {7'd87, cpu_pkg::CYCLE12};  // RETS
            12'hFDF: begin                               // RET
                entry  = {7'd88, cpu_pkg::CYCLE7};
                skip_d = 1'b1;
            end
            12'b1111_1110_00??: entry = {7'd89, cpu_pkg::CYCLE5};   // LD SPH, r
            12'b1111_1110_01??: entry = {7'd90, cpu_pkg::CYCLE5};   // LD r, SPH
            12'hFE8: begin                               // JPBA
                entry  = {7'd91, cpu_pkg::CYCLE5};
                skip_d = 1'b1;
            end
            12'b1111_1111_00??: entry = {7'd92, cpu_pkg::CYCLE5};   // LD SPL, r
            12'b1111_1111_01??: entry = {7'd93, cpu_pkg::CYCLE5};   // LD r, SPL
            12'hFF8: begin                               // HALT
                entry  = {7'd94, cpu_pkg::CYCLE5};
                halt_d = 1'b1;
            end
            12'hFF9: begin                               // SLP
                entry  = {7'd95, cpu_pkg::CYCLE5};
                halt_d = 1'b1;
            end
            12'hFFB: entry = {7'd96, cpu_pkg::CYCLE5};   // NOP5
            12'hFFF: entry = {7'd97, cpu_pkg::CYCLE7};   // NOP7
            default: entry = {7'd0, cpu_pkg::CYCLE5};
        endcase
    end

    // Outputs hold from one fetch tick to the next
    always_ff @(posedge clk) begin
        if (reset) begin
            skip_pc_increment    <= 1'b0;
            microcode_start_addr <= '0;
            cycle_length         <= cpu_pkg::CYCLE5;
            disable_interrupt    <= 1'b0;
            halt                 <= 1'b0;
            immed                <= '0;
        end else if (decode_en) begin
            skip_pc_increment    <= skip_d;
            microcode_start_addr <= entry[`UADDR_W+1:2];
            cycle_length         <= cpu_pkg::instr_length'(entry[1:0]);
            disable_interrupt    <= dis_d;
            halt                 <= halt_d;
            immed                <= opcode[`IMMED_W-1:0];   // Always the low byte
        end
    end

endmodule

// ==== verilog/instr_sequencer.sv ====
module instr_sequencer (
    input  logic clk,
    input  logic reset,
    input  logic clk_en,
    input  logic irq_request,
    input  logic last_tick,
    input  logic disable_interrupt,
    input  logic halt,
    output logic decode_en,
    output logic load_en,
    output logic advance_en,
    output logic instr_start,
    output logic irq_ack,
    output logic halted
);

    cpu_pkg::seq_state state;
    cpu_pkg::seq_state state_next;
    logic              irq_mask;   // Set for one boundary after PSET
    logic              irq_take;

    // Interrupts only at a boundary or while parked
    assign irq_take = clk_en && irq_request &&
                      ((state == cpu_pkg::FETCH && !irq_mask) ||
                       state == cpu_pkg::HALTED);

    assign decode_en  = clk_en && state == cpu_pkg::FETCH && !irq_take;
    assign load_en    = decode_en;   // Timer arms on the fetch tick
    assign advance_en = clk_en && state == cpu_pkg::EXECUTE && last_tick;
    assign halted     = state == cpu_pkg::HALTED;

    always_comb begin
        state_next = state;
        case (state)
            cpu_pkg::FETCH: begin
                if (decode_en)
                    state_next = cpu_pkg::EXECUTE;
            end
            cpu_pkg::EXECUTE: begin
                if (advance_en)
                    state_next = halt ? cpu_pkg::HALTED : cpu_pkg::FETCH;
            end
            cpu_pkg::HALTED: begin
                if (irq_take)
                    state_next = cpu_pkg::FETCH;
            end
            default: state_next = cpu_pkg::FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= cpu_pkg::FETCH;
            irq_mask    <= 1'b0;
            instr_start <= 1'b0;
            irq_ack     <= 1'b0;
        end else begin
            state       <= state_next;
            instr_start <= decode_en;   // Decode outputs valid in this clock
            irq_ack     <= irq_take;
            if (advance_en)
                irq_mask <= disable_interrupt;   // Flag of the ending instruction
        end
    end

endmodule

// ==== verilog/pc_unit.sv ====
`include "cpu_macros.svh"

module pc_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              advance_en,
    input  logic              skip_pc_increment,
    input  logic              jump_load,
    input  logic [`PC_W-1:0]  jump_target,
    output logic [`PC_W-1:0]  pc
);

    // Only the final tick of an instruction moves the pc
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (advance_en) begin
            if (jump_load)
                pc <= jump_target;   // External load wins
            else if (!skip_pc_increment)
                pc <= pc + 1'b1;     // Wraps at 4096
        end
    end

endmodule
